// ==== hdl/div_pkg.sv ====
`default_nettype none

package div_pkg;

  // operand and result width
  localparam int xlen = 32;

  // partial remainder holds a full product-width value plus a sign bit,
  // so a trial subtraction that goes below zero is visible in the top bit
  localparam int rem_w = 2 * xlen + 1;

  // each radix-4 stage retires two quotient bits
  localparam int num_stages = xlen / 2;

  // operand stage, the radix-4 stages, then the result stage
  localparam int div_latency = num_stages + 2;

  // opcode encoding matches the core's divide unit field
  typedef enum logic [1:0] {
    OP_DIV  = 2'd0,
    OP_DIVU = 2'd1,
    OP_REM  = 2'd2,
    OP_REMU = 2'd3
  } div_op_e;

endpackage

`default_nettype wire

// ==== hdl/div_stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one slot of the divider pipeline, driven from the registers of the
// stage that owns it and read by the stage that follows
interface div_stage_if
  import div_pkg::*;
();

  logic             valid;
  logic [rem_w-1:0] rem;
  logic [xlen-1:0]  quo;
  logic [xlen-1:0]  divisor;
  logic             neg_quo;
  logic             neg_rem;
  logic             take_rem;

  modport src (
    output valid,
    output rem,
    output quo,
    output divisor,
    output neg_quo,
    output neg_rem,
    output take_rem
  );

  modport dst (
    input valid,
    input rem,
    input quo,
    input divisor,
    input neg_quo,
    input neg_rem,
    input take_rem
  );

endinterface

`default_nettype wire

// ==== hdl/div_operand_prep.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep
  import div_pkg::*;
(
  input  logic            CLK,
  input  logic            RST_N,
  input  logic            adv,
  input  logic            in_valid,
  input  logic [xlen-1:0] in_a,
  input  logic [xlen-1:0] in_b,
  input  div_op_e         in_op,
  div_stage_if.src        slot
);

  logic            is_signed;
  logic            a_neg;
  logic            b_neg;
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;
  logic            neg_quo_d;
  logic            neg_rem_d;
  logic            take_rem_d;

  always_comb begin
    is_signed = (in_op == OP_DIV) || (in_op == OP_REM);
    a_neg     = is_signed & in_a[xlen-1];
    b_neg     = is_signed & in_b[xlen-1];

    // the most negative value maps onto itself, which is its correct
    // magnitude when read as unsigned
    a_mag = a_neg ? ('0 - in_a) : in_a;
    b_mag = b_neg ? ('0 - in_b) : in_b;

    neg_quo_d  = 1'b0;
    neg_rem_d  = 1'b0;
    take_rem_d = 1'b0;
    case (in_op)
      OP_DIV: begin
        neg_quo_d = a_neg ^ b_neg;
      end
      OP_REM: begin
        // remainder follows the sign of the dividend
        neg_rem_d  = a_neg;
        take_rem_d = 1'b1;
      end
      OP_REMU: begin
        take_rem_d = 1'b1;
      end
      default: begin
        neg_quo_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      slot.valid <= 1'b0;
    end else if (adv) begin
      slot.valid <= in_valid & adv;
    end
  end

  always_ff @(posedge CLK) begin
    if (adv) begin
      slot.rem      <= {{(rem_w - xlen){1'b0}}, a_mag};
      slot.quo      <= '0;
      slot.divisor  <= b_mag;
      slot.neg_quo  <= neg_quo_d;
      slot.neg_rem  <= neg_rem_d;
      slot.take_rem <= take_rem_d;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/div_radix4_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_radix4_stage
  import div_pkg::*;
#(
  parameter int stage_idx = 0
)
(
  input  logic     CLK,
  input  logic     RST_N,
  input  logic     adv,
  div_stage_if.dst prev,
  div_stage_if.src next
);

  logic [rem_w-1:0] div_x1;
  logic [rem_w-1:0] div_x2;
  logic [rem_w-1:0] div_x3;
  logic [rem_w-1:0] trial_1;
  logic [rem_w-1:0] trial_2;
  logic [rem_w-1:0] trial_3;
  logic [rem_w-1:0] rem_nxt;
  logic [1:0]       digit;
  logic [xlen-1:0]  quo_nxt;

  // divisor multiples aligned to the quotient digit this stage decides
  always_comb begin
    div_x1 = {{(rem_w - xlen){1'b0}}, prev.divisor} << (2 * (num_stages - 1 - stage_idx));
    div_x2 = div_x1 << 1;
    div_x3 = div_x1 + div_x2;
  end

  always_comb begin
    trial_1 = prev.rem - div_x1;
    trial_2 = prev.rem - div_x2;
    trial_3 = prev.rem - div_x3;
  end

  // keep the largest multiple that still leaves a non-negative remainder
  always_comb begin
    if (!trial_3[rem_w-1]) begin
      digit   = 2'd3;
      rem_nxt = trial_3;
    end else if (!trial_2[rem_w-1]) begin
      digit   = 2'd2;
      rem_nxt = trial_2;
    end else if (!trial_1[rem_w-1]) begin
      digit   = 2'd1;
      rem_nxt = trial_1;
    end else begin
      digit   = 2'd0;
      rem_nxt = prev.rem;
    end
  end

  // stage 0 owns the top two quotient bits, stage 15 the bottom two
  always_comb begin
    quo_nxt = prev.quo;
    quo_nxt[xlen - 1 - 2 * stage_idx -: 2] = digit;
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      next.valid <= 1'b0;
    end else if (adv) begin
      next.valid <= prev.valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (adv) begin
      next.rem      <= rem_nxt;
      next.quo      <= quo_nxt;
      next.divisor  <= prev.divisor;
      next.neg_quo  <= prev.neg_quo;
      next.neg_rem  <= prev.neg_rem;
      next.take_rem <= prev.take_rem;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/div_result_fixup.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_result_fixup
  import div_pkg::*;
(
  input  logic            CLK,
  input  logic            RST_N,
  input  logic            r_ready,
  output logic            adv,
  div_stage_if.dst        prev,
  output logic            r_valid,
  output logic [xlen-1:0] r_data
);

  logic [xlen-1:0] rem_low;
  logic [xlen-1:0] quo_signed;
  logic [xlen-1:0] rem_signed;
  logic [xlen-1:0] result;

  // the whole pipeline moves only when the output register is free
  // or is being emptied in this cycle
  assign adv = !r_valid || r_ready;

  // after the last stage the remainder fits in the low word
  assign rem_low = prev.rem[xlen-1:0];

  always_comb begin
    quo_signed = prev.neg_quo ? ('0 - prev.quo) : prev.quo;
    rem_signed = prev.neg_rem ? ('0 - rem_low) : rem_low;
  end

  always_comb begin
    if (prev.take_rem) begin
      result = rem_signed;
    end else begin
      result = quo_signed;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      r_valid <= 1'b0;
    end else if (adv) begin
      r_valid <= prev.valid;
    end
  end

  // data holds while a result waits for r_ready
  always_ff @(posedge CLK) begin
    if (adv) begin
      r_data <= result;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/div_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_top
  import div_pkg::*;
(
  input  logic            CLK,
  input  logic            RST_N,

  input  logic            in_valid,
  output logic            in_ready,
  input  logic [xlen-1:0] in_a,
  input  logic [xlen-1:0] in_b,
  input  div_op_e         in_op,

  output logic            r_valid,
  input  logic            r_ready,
  output logic [xlen-1:0] r_data
);

  logic adv;

  // slot 0 comes out of the operand stage, slot 16 feeds the result stage
  div_stage_if stage_if [num_stages:0] ();

  // a request can enter whenever the pipeline advances
  assign in_ready = adv;

  div_operand_prep u_operand_prep (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .adv      (adv),
    .in_valid (in_valid),
    .in_a     (in_a),
    .in_b     (in_b),
    .in_op    (in_op),
    .slot     (stage_if[0])
  );

  for (genvar i = 0; i < num_stages; i++) begin : g_stage
    div_radix4_stage #(
      .stage_idx (i)
    ) u_radix4_stage (
      .CLK   (CLK),
      .RST_N (RST_N),
      .adv   (adv),
      .prev  (stage_if[i]),
      .next  (stage_if[i+1])
    );
  end

  div_result_fixup u_result_fixup (
    .CLK     (CLK),
    .RST_N   (RST_N),
    .r_ready (r_ready),
    .adv     (adv),
    .prev    (stage_if[num_stages]),
    .r_valid (r_valid),
    .r_data  (r_data)
  );

endmodule

`default_nettype wire

// ==== tests/div_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_checker
  import div_pkg::*;
(
  input  logic            CLK,
  input  logic            RST_N,
  input  logic            in_valid,
  input  logic            in_ready,
  input  logic [xlen-1:0] in_a,
  input  logic [xlen-1:0] in_b,
  input  div_op_e         in_op,
  input  logic            exp_known,
  input  logic [xlen-1:0] exp_data,
  input  logic            r_valid,
  input  logic            r_ready,
  input  logic [xlen-1:0] r_data,
  output int              errors,
  output int              accepted,
  output int              consumed,
  output int              pending
);

  logic [xlen-1:0] exp_q [$];
  int              cyc_q [$];
  int              cyc;
  logic            stall_seen;
  logic            was_held;
  logic [xlen-1:0] held_data;
  logic            reset_checked;

  // 64-bit arithmetic truncates toward zero and the most negative value
  // over minus one lands on 2**31, whose low word is the wrapped quotient
  function automatic logic [xlen-1:0] predict(input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b,
                                              input div_op_e op);
    longint      sa;
    longint      sb;
    longint      ua;
    longint      ub;
    logic [63:0] res;
    sa = {{xlen{a[xlen-1]}}, a};
    sb = {{xlen{b[xlen-1]}}, b};
    ua = {{xlen{1'b0}}, a};
    ub = {{xlen{1'b0}}, b};
    case (op)
      OP_DIV:  res = sa / sb;
      OP_REM:  res = sa % sb;
      OP_DIVU: res = ua / ub;
      default: res = ua % ub;
    endcase
    return res[xlen-1:0];
  endfunction

  initial begin
    errors        = 0;
    accepted      = 0;
    consumed      = 0;
    pending       = 0;
    cyc           = 0;
    stall_seen    = 1'b0;
    was_held      = 1'b0;
    held_data     = '0;
    reset_checked = 1'b0;
  end

  always @(posedge CLK) begin
    logic [xlen-1:0] pred;
    logic [xlen-1:0] want;
    int              acc_cyc;
    if (RST_N) begin
      cyc++;
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (r_valid !== 1'b0) begin
          $display("ERROR r_valid after reset: got %h expected %h", r_valid, 1'b0);
          errors++;
        end
        if (in_ready !== 1'b1) begin
          $display("ERROR in_ready after reset: got %h expected %h", in_ready, 1'b1);
          errors++;
        end
      end
      // a result held back last cycle must still be there, unchanged
      if (was_held) begin
        if (r_valid !== 1'b1) begin
          $display("a stalled result disappeared before it was consumed");
          errors++;
        end else if (r_data !== held_data) begin
          $display("ERROR r_data under stall: got %h expected %h", r_data, held_data);
          errors++;
        end
      end
      if (r_valid && !r_ready) begin
        stall_seen = 1'b1;
        if (in_ready !== 1'b0) begin
          $display("ERROR in_ready under stall: got %h expected %h", in_ready, 1'b0);
          errors++;
        end
      end
      if (r_valid && r_ready) begin
        if (exp_q.size() == 0) begin
          $display("a result came out with no request outstanding");
          errors++;
        end else begin
          want    = exp_q.pop_front();
          acc_cyc = cyc_q.pop_front();
          consumed++;
          if (r_data !== want) begin
            $display("ERROR r_data: got %h expected %h", r_data, want);
            errors++;
          end
          if (!stall_seen && (cyc - acc_cyc) != div_latency) begin
            $display("result %0d took %0d cycles instead of %0d",
                     consumed, cyc - acc_cyc, div_latency);
            errors++;
          end
        end
      end
      if (in_valid && in_ready) begin
        pred = predict(in_a, in_b, in_op);
        if (exp_known && pred !== exp_data) begin
          $display("table entry %0d does not match the division rules", accepted);
          errors++;
        end
        exp_q.push_back(pred);
        cyc_q.push_back(cyc);
        accepted++;
      end
      was_held  = r_valid && !r_ready;
      held_data = r_data;
      pending   = exp_q.size();
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_div_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_div_top
  import div_pkg::*;
();

  localparam int num_directed   = 20;
  localparam int num_random     = 200;
  localparam int num_entries    = num_directed + num_random;
  localparam int half_run       = num_entries / 2;
  localparam int timeout_cycles = (num_entries + div_latency + 50) * 2;
  localparam logic [7:0] ready_pattern = 8'b1101_0110;

  logic            CLK;
  logic            RST_N;
  logic            in_valid;
  logic            in_ready;
  logic [xlen-1:0] in_a;
  logic [xlen-1:0] in_b;
  div_op_e         in_op;
  logic            r_valid;
  logic            r_ready;
  logic [xlen-1:0] r_data;
  logic            cur_known;
  logic [xlen-1:0] cur_exp;
  int              errors;
  int              accepted;
  int              consumed;
  int              pending;

  logic [xlen-1:0] tab_a     [num_entries];
  logic [xlen-1:0] tab_b     [num_entries];
  div_op_e         tab_op    [num_entries];
  logic [xlen-1:0] tab_exp   [num_entries];
  logic            tab_known [num_entries];
  int              fill;

  div_top uut (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_a     (in_a),
    .in_b     (in_b),
    .in_op    (in_op),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r_data   (r_data)
  );

  div_checker chk (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_a      (in_a),
    .in_b      (in_b),
    .in_op     (in_op),
    .exp_known (cur_known),
    .exp_data  (cur_exp),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .r_data    (r_data),
    .errors    (errors),
    .accepted  (accepted),
    .consumed  (consumed),
    .pending   (pending)
  );

  always #50 CLK = ~CLK;

  task automatic add_directed(input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                              input div_op_e op, input logic [xlen-1:0] exp);
    tab_a[fill]     = a;
    tab_b[fill]     = b;
    tab_op[fill]    = op;
    tab_exp[fill]   = exp;
    tab_known[fill] = 1'b1;
    fill++;
  endtask

  initial begin : main
    int              idx;
    int              cyc;
    integer          seed;
    logic [xlen-1:0] ra;
    logic [xlen-1:0] rb;
    logic [xlen-1:0] rs;
    CLK       = 1'b0;
    RST_N     = 1'b0;
    in_valid  = 1'b0;
    in_a      = '0;
    in_b      = '0;
    in_op     = OP_DIV;
    // held low until after reset so in_ready then depends on r_valid alone
    r_ready   = 1'b0;
    cur_known = 1'b0;
    cur_exp   = '0;
    seed      = 32'h400161b0;
    fill      = 0;
    add_directed(32'd100, 32'd7, OP_DIVU, 32'd14);
    add_directed(32'd100, 32'd7, OP_REMU, 32'd2);
    add_directed(32'hFFFF_FF9C, 32'd7, OP_DIV, 32'hFFFF_FFF2);
    add_directed(32'hFFFF_FF9C, 32'd7, OP_REM, 32'hFFFF_FFFE);
    add_directed(32'd100, 32'hFFFF_FFF9, OP_DIV, 32'hFFFF_FFF2);
    add_directed(32'd100, 32'hFFFF_FFF9, OP_REM, 32'd2);
    add_directed(32'hFFFF_FF9C, 32'hFFFF_FFF9, OP_DIV, 32'd14);
    add_directed(32'hFFFF_FF9C, 32'hFFFF_FFF9, OP_REM, 32'hFFFF_FFFE);
    add_directed(32'h8000_0000, 32'hFFFF_FFFF, OP_DIV, 32'h8000_0000);
    add_directed(32'h8000_0000, 32'hFFFF_FFFF, OP_REM, 32'd0);
    add_directed(32'h8000_0000, 32'hFFFF_FFFF, OP_DIVU, 32'd0);
    add_directed(32'h8000_0000, 32'hFFFF_FFFF, OP_REMU, 32'h8000_0000);
    add_directed(32'hFFFF_FFFF, 32'd1, OP_DIVU, 32'hFFFF_FFFF);
    add_directed(32'hFFFF_FFFF, 32'd1, OP_REMU, 32'd0);
    add_directed(32'h1234_5678, 32'h1234_5678, OP_DIV, 32'd1);
    add_directed(32'h1234_5678, 32'h1234_5678, OP_REMU, 32'd0);
    add_directed(32'd5, 32'd9, OP_DIVU, 32'd0);
    add_directed(32'd5, 32'd9, OP_REMU, 32'd5);
    add_directed(32'hFFFF_FFFB, 32'd9, OP_DIV, 32'd0);
    add_directed(32'hFFFF_FFFB, 32'd9, OP_REM, 32'hFFFF_FFFB);
    // random divisors are shifted down so that short quotients and long ones both occur
    for (int i = num_directed; i < num_entries; i++) begin
      ra = $random(seed);
      rb = $random(seed);
      rs = $random(seed);
      rb = rb >> rs[4:0];
      if (rb == '0) begin
        rb = 32'd1;
      end
      tab_a[i]     = ra;
      tab_b[i]     = rb;
      tab_op[i]    = div_op_e'(rs[9:8]);
      tab_exp[i]   = '0;
      tab_known[i] = 1'b0;
    end
    repeat (5) @(posedge CLK);
    #1;
    RST_N = 1'b1;
    @(posedge CLK);
    idx = 0;
    cyc = 0;
    while (idx < num_entries) begin
      #1;
      in_valid  = (cyc % 7) != 3;
      in_a      = tab_a[idx];
      in_b      = tab_b[idx];
      in_op     = tab_op[idx];
      cur_exp   = tab_exp[idx];
      cur_known = tab_known[idx];
      @(posedge CLK);
      if (in_valid && in_ready) begin
        idx++;
      end
      cyc++;
    end
    #1;
    in_valid = 1'b0;
    wait (consumed == num_entries);
    // extra cycles expose any duplicated result
    repeat (div_latency + 4) @(posedge CLK);
    $display("accepted %0d consumed %0d pending %0d errors %0d",
             accepted, consumed, pending, errors);
    if (errors == 0 && pending == 0 && accepted == num_entries && consumed == num_entries) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // r_ready stays high for the first half, then follows the pattern
  initial begin : ready_driver
    int k;
    k = 0;
    wait (RST_N === 1'b1);
    forever begin
      @(posedge CLK);
      #1;
      if (k < half_run) begin
        r_ready = 1'b1;
      end else begin
        r_ready = ready_pattern[k % 8];
      end
      k++;
    end
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge CLK);
    $display("timeout after %0d cycles with %0d of %0d results received",
             timeout_cycles, consumed, num_entries);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/div_pkg.sv
hdl/div_stage_if.sv
hdl/div_operand_prep.sv
hdl/div_radix4_stage.sv
hdl/div_result_fixup.sv
hdl/div_top.sv
tests/div_checker.sv
tests/tb_div_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_div_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
